// File: bench/vlsu_golden.txt
# M addr data or V addr data: memory or VRF word set before the run
# R op vsew vl base stride vd: request; EM or EV addr data: expected final word; all hex
M 00 deadbeef
V 18 44332211
V 19 88776655
R 0 2 06 00000000 00000000 02
R 2 0 06 00000081 00000000 03
R 1 1 03 00000022 00000008 04
R 3 2 00 000000c0 00000010 05
R 3 2 03 000000c0 00000010 05
EV 10 deadbeef
EV 11 07060504
EV 12 0b0a0908
EV 13 0f0e0d0c
EV 14 13121110
EV 15 17161514
EV 16 eeeeee16
EM 80 33221180
EM 84 87665544
EM 88 8b8a8988
EV 20 2b2a2322
EV 21 eeee3332
EV 22 eeeeee22
EM c0 eeeeee28
EM c4 c7c6c5c4
EM d0 eeeeee29
EM e0 eeeeee2a

// File: filelist.f
+incdir+src
src/vlsu_pkg.sv
src/vlsu_ifs.sv
src/vlsu_ctrl.sv
src/vlsu_elem_counter.sv
src/reorder_buffer.sv
src/vlsu_mem_stage.sv
src/vlsu_vrf_stage.sv
src/vlsu_top.sv
bench/tb_vlsu.sv

// File: bench/tb_vlsu.sv
//////////////////////////////////////////////////
// Vector LSU testbench
// Memory and VRF models, requests and expected
// contents taken from the golden file
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "vlsu_defs.svh"

module tb_vlsu
  import vlsu_pkg::*;
();

  localparam int TIMEOUT   = 2000;
  localparam int MEM_WORDS = 64;
  localparam int VRF_WORDS = `VLSU_NR_VREGS * `VLSU_VELE;

  logic                  clk_i;
  logic                  rst_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  vlsu_op_e              req_op_i;
  vsew_e                 req_vsew_i;
  logic [`VLSU_VL_W-1:0] req_vl_i;
  mem_addr_t             req_base_i;
  mem_addr_t             req_stride_i;
  vreg_idx_t             req_vd_i;
  logic                  finished_o;
  vreg_addr_t            vrf_waddr_o;
  elen_t                 vrf_wdata_o;
  logic                  vrf_we_o;
  strb_t                 vrf_wbe_o;
  logic                  vrf_wvalid_i;
  vreg_addr_t            vrf_raddr_o;
  logic                  vrf_re_o;
  elen_t                 vrf_rdata_i;
  logic                  vrf_rvalid_i;
  logic                  mem_valid_o;
  logic                  mem_ready_i;
  mem_addr_t             mem_addr_o;
  logic                  mem_we_o;
  strb_t                 mem_strb_o;
  elen_t                 mem_wdata_o;
  rob_id_t               mem_id_o;
  logic                  mem_last_o;
  logic                  mem_result_valid_i;
  rob_id_t               mem_result_id_i;
  elen_t                 mem_result_rdata_i;

  // Models and run state
  elen_t       mem_model [MEM_WORDS];
  elen_t       vrf_model [VRF_WORDS];
  logic [15:0] lfsr_q = 16'd49;
  int          cyc = 0;
  int          checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          fin_count = 0;
  int          mem_beat = 0;
  logic        rd_wait = 1'b0;
  logic        idle_watch = 1'b0;
  logic        timed_out = 1'b0;
  vlsu_op_e    cur_op;
  vsew_e       cur_vsew;
  logic [7:0]  cur_vl;
  mem_addr_t   cur_base;
  mem_addr_t   cur_stride;

  // Requests, expected words, load results in flight
  logic [1:0]  rq_op [$];
  logic [1:0]  rq_vsew [$];
  logic [7:0]  rq_vl [$];
  mem_addr_t   rq_base [$];
  mem_addr_t   rq_stride [$];
  vreg_idx_t   rq_vd [$];
  vreg_addr_t  ev_addr [$];
  elen_t       ev_data [$];
  mem_addr_t   em_addr [$];
  elen_t       em_data [$];
  rob_id_t     pend_id [$];
  elen_t       pend_data [$];
  int          pend_due [$];

  vlsu_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Strobe of store beat k from the element layout of the request
  function automatic strb_t strb_for_beat(input int k);
    int        esz;
    int        rem;
    logic      strided;
    mem_addr_t a;
    esz     = 1 << cur_vsew;
    strided = (cur_op == STORE_STRIDED) || (cur_op == LOAD_STRIDED);
    if (strided || cur_base[1:0] != 2'b00) begin
      a = strided ? cur_base + k * cur_stride : cur_base + k * esz;
      return strb_t'(((1 << esz) - 1) << a[1:0]);
    end
    rem = cur_vl * esz - 4 * k;
    return (rem >= 4) ? strb_t'(4'hF) : strb_t'((1 << rem) - 1);
  endfunction

  // Memory beats of the request, one per element unless aligned unit-stride
  function automatic int beats_total();
    int   esz;
    logic strided;
    esz     = 1 << cur_vsew;
    strided = (cur_op == STORE_STRIDED) || (cur_op == LOAD_STRIDED);
    if (strided || cur_base[1:0] != 2'b00) begin
      return cur_vl;
    end
    return (cur_vl * esz + 3) / 4;
  endfunction

  task automatic check_strb(input strb_t exp);
    checks++;
    if (mem_strb_o !== exp) begin
      value_errors++;
      $display("Error at %0t ns: mem_strb_o = %b, expected %b", $time, mem_strb_o, exp);
    end
  endtask

  task automatic check_last(input logic exp);
    checks++;
    if (mem_last_o !== exp) begin
      value_errors++;
      $display("Error at %0t ns: mem_last_o = %b, expected %b", $time, mem_last_o, exp);
    end
  endtask

  task automatic check_vrf(input vreg_addr_t a, input elen_t exp);
    checks++;
    if (vrf_model[a] !== exp) begin
      value_errors++;
      $display("Error at %0t ns: vrf_model[%h] = %h, expected %h",
               $time, a, vrf_model[a], exp);
    end
  endtask

  task automatic check_mem(input mem_addr_t a, input elen_t exp);
    checks++;
    if (mem_model[a[7:2]] !== exp) begin
      value_errors++;
      $display("Error at %0t ns: mem_model[%h] = %h, expected %h",
               $time, a, mem_model[a[7:2]], exp);
    end
  endtask

  task automatic read_golden();
    int          fd;
    int          n;
    string       line;
    string       kind;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    fd = $fopen("bench/vlsu_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open bench/vlsu_golden.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
        if (kind == "M") begin
          mem_model[f0[7:2]] = f1;
        end else if (kind == "V") begin
          vrf_model[f0[7:0]] = f1;
        end else if (kind == "R" && n == 7) begin
          rq_op.push_back(f0[1:0]);
          rq_vsew.push_back(f1[1:0]);
          rq_vl.push_back(f2[7:0]);
          rq_base.push_back(f3);
          rq_stride.push_back(f4);
          rq_vd.push_back(vreg_idx_t'(f5));
        end else if (kind == "EM") begin
          em_addr.push_back(f0);
          em_data.push_back(f1);
        end else if (kind == "EV") begin
          ev_addr.push_back(vreg_addr_t'(f0));
          ev_data.push_back(f1);
        end else begin
          other_errors++;
          $display("Unreadable line in golden file: %s", line);
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Model responses, 2 ns after the edge
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int bits;
    int pick;
    cyc = cyc + 1;
    #2;
    take_bits(2, bits);
    mem_ready_i = (bits != 0);
    take_bits(2, bits);
    vrf_wvalid_i = (bits != 0);
    take_bits(1, bits);
    vrf_rvalid_i = rd_wait && bits[0];
    vrf_rdata_i  = vrf_model[vrf_raddr_o];
    // First result whose delay ran out, so returns can overtake
    pick = -1;
    for (int k = 0; k < pend_due.size(); k++) begin
      if (pick < 0 && pend_due[k] <= cyc) begin
        pick = k;
      end
    end
    if (pick >= 0) begin
      mem_result_valid_i = 1'b1;
      mem_result_id_i    = pend_id[pick];
      mem_result_rdata_i = pend_data[pick];
      pend_id.delete(pick);
      pend_data.delete(pick);
      pend_due.delete(pick);
    end else begin
      mem_result_valid_i = 1'b0;
    end
  end

  // Handshakes seen at the falling edge
  always @(negedge clk_i) begin
    int bits;
    if (!rst_i) begin
      if (mem_valid_o && mem_ready_i) begin
        check_last(mem_beat == beats_total() - 1);
        if (mem_we_o) begin
          check_strb(strb_for_beat(mem_beat));
          for (int j = 0; j < 4; j++) begin
            if (mem_strb_o[j]) begin
              mem_model[mem_addr_o[7:2]][8*j +: 8] = mem_wdata_o[8*j +: 8];
            end
          end
        end else begin
          take_bits(2, bits);
          pend_id.push_back(mem_id_o);
          pend_data.push_back(mem_model[mem_addr_o[7:2]]);
          pend_due.push_back(cyc + 1 + bits);
        end
        mem_beat = mem_beat + 1;
      end
      if (vrf_we_o && vrf_wvalid_i) begin
        for (int j = 0; j < 4; j++) begin
          if (vrf_wbe_o[j]) begin
            vrf_model[vrf_waddr_o][8*j +: 8] = vrf_wdata_o[8*j +: 8];
          end
        end
      end
      if (vrf_re_o) begin
        rd_wait = !vrf_rvalid_i;
      end
      if (finished_o) begin
        fin_count = fin_count + 1;
      end
      if (idle_watch && (mem_valid_o || vrf_we_o || vrf_re_o || finished_o || !req_ready_o)) begin
        other_errors++;
        $display("Zero-length request caused activity or dropped ready at %0t ns", $time);
      end
    end
  end

  //////////////////////////////////////////////////
  // Request sequence
  //////////////////////////////////////////////////

  task automatic run_request(input int i);
    int waited;
    int fin_before;
    waited = 0;
    @(negedge clk_i);
    while (!req_ready_o && waited <= TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    if (!req_ready_o) begin
      other_errors++;
      timed_out = 1'b1;
      $display("Timeout waiting for req_ready_o at %0t ns", $time);
    end else begin
      @(posedge clk_i);
      #2;
      cur_op       = vlsu_op_e'(rq_op[i]);
      cur_vsew     = vsew_e'(rq_vsew[i]);
      cur_vl       = rq_vl[i];
      cur_base     = rq_base[i];
      cur_stride   = rq_stride[i];
      mem_beat     = 0;
      fin_before   = fin_count;
      req_valid_i  = 1'b1;
      req_op_i     = cur_op;
      req_vsew_i   = cur_vsew;
      req_vl_i     = cur_vl;
      req_base_i   = cur_base;
      req_stride_i = cur_stride;
      req_vd_i     = rq_vd[i];
      @(posedge clk_i);
      #2;
      req_valid_i = 1'b0;
      if (cur_vl == 0) begin
        // Observation window for a request that must stay silent
        idle_watch = 1'b1;
        repeat (6) @(posedge clk_i);
        idle_watch = 1'b0;
      end else begin
        waited = 0;
        while (fin_count == fin_before && waited <= TIMEOUT) begin
          waited++;
          @(posedge clk_i);
        end
        if (fin_count == fin_before) begin
          other_errors++;
          timed_out = 1'b1;
          $display("Timeout waiting for finished_o at %0t ns", $time);
        end else begin
          repeat (2) @(posedge clk_i);
          if (fin_count != fin_before + 1) begin
            other_errors++;
            $display("Request %0d gave %0d finished pulses instead of one", i,
                     fin_count - fin_before);
          end
        end
      end
    end
  endtask

  initial begin
    int n_active;
    rst_i              = 1'b1;
    req_valid_i        = 1'b0;
    req_op_i           = LOAD_UNIT;
    req_vsew_i         = EW_8;
    req_vl_i           = '0;
    req_base_i         = '0;
    req_stride_i       = '0;
    req_vd_i           = '0;
    vrf_wvalid_i       = 1'b0;
    vrf_rdata_i        = '0;
    vrf_rvalid_i       = 1'b0;
    mem_ready_i        = 1'b0;
    mem_result_valid_i = 1'b0;
    mem_result_id_i    = '0;
    mem_result_rdata_i = '0;
    // Each memory byte holds its own address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = {8'(4*i+3), 8'(4*i+2), 8'(4*i+1), 8'(4*i)};
    end
    for (int i = 0; i < VRF_WORDS; i++) begin
      vrf_model[i] = {24'hEEEEEE, 8'(i)};
    end
    read_golden();
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    n_active = 0;
    for (int i = 0; i < rq_op.size() && !timed_out; i++) begin
      run_request(i);
      if (rq_vl[i] != 0) begin
        n_active++;
      end
    end
    repeat (4) @(posedge clk_i);
    if (fin_count != n_active) begin
      other_errors++;
      $display("Saw %0d finished pulses for %0d requests", fin_count, n_active);
    end
    for (int i = 0; i < ev_addr.size(); i++) begin
      check_vrf(ev_addr[i], ev_data[i]);
    end
    for (int i = 0; i < em_addr.size(); i++) begin
      check_mem(em_addr[i], em_data[i]);
    end
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src/vlsu_top.sv
//////////////////////////////////////////////////
// Vector load/store unit
// Control, memory and VRF stages, reorder buffer
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "vlsu_defs.svh"

module vlsu_top
  import vlsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vlsu_op_e              req_op_i,
  input  vsew_e                 req_vsew_i,
  input  logic [`VLSU_VL_W-1:0] req_vl_i,
  input  mem_addr_t             req_base_i,
  input  mem_addr_t             req_stride_i,
  input  vreg_idx_t             req_vd_i,
  output logic                  finished_o,
  // VRF
  output vreg_addr_t            vrf_waddr_o,
  output elen_t                 vrf_wdata_o,
  output logic                  vrf_we_o,
  output strb_t                 vrf_wbe_o,
  input  logic                  vrf_wvalid_i,
  output vreg_addr_t            vrf_raddr_o,
  output logic                  vrf_re_o,
  input  elen_t                 vrf_rdata_i,
  input  logic                  vrf_rvalid_i,
  // Memory
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output mem_addr_t             mem_addr_o,
  output logic                  mem_we_o,
  output strb_t                 mem_strb_o,
  output elen_t                 mem_wdata_o,
  output rob_id_t               mem_id_o,
  output logic                  mem_last_o,
  input  logic                  mem_result_valid_i,
  input  rob_id_t               mem_result_id_i,
  input  elen_t                 mem_result_rdata_i
);

  logic  mem_done;
  logic  vrf_done;
  logic  st_valid;
  elen_t st_data;
  logic  st_take;

  vlsu_req_if req_bus ();
  rob_if      rob_bus ();

  vlsu_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_vsew_i  (req_vsew_i),
    .req_vl_i    (req_vl_i),
    .req_base_i  (req_base_i),
    .req_stride_i(req_stride_i),
    .req_vd_i    (req_vd_i),
    .req_ready_o (req_ready_o),
    .finished_o  (finished_o),
    .req         (req_bus.ctrl),
    .mem_done_i  (mem_done),
    .vrf_done_i  (vrf_done)
  );

  reorder_buffer #(
    .DEPTH(`VLSU_OUTSTANDING)
  ) u_rob (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .rob  (rob_bus.buffer)
  );

  vlsu_mem_stage u_mem_stage (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req               (req_bus.stage),
    .rob               (rob_bus.fill),
    .st_valid_i        (st_valid),
    .st_data_i         (st_data),
    .st_take_o         (st_take),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_addr_o        (mem_addr_o),
    .mem_we_o          (mem_we_o),
    .mem_strb_o        (mem_strb_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_id_o          (mem_id_o),
    .mem_last_o        (mem_last_o),
    .mem_result_valid_i(mem_result_valid_i),
    .mem_result_id_i   (mem_result_id_i),
    .mem_result_rdata_i(mem_result_rdata_i),
    .done_o            (mem_done)
  );

  vlsu_vrf_stage u_vrf_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req         (req_bus.stage),
    .rob         (rob_bus.drain),
    .st_valid_o  (st_valid),
    .st_data_o   (st_data),
    .st_take_i   (st_take),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wvalid_i(vrf_wvalid_i),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_rdata_i (vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i),
    .done_o      (vrf_done)
  );

endmodule

// File: src/vlsu_vrf_stage.sv
//////////////////////////////////////////////////
// VRF stage
// Load write-back with lane alignment, store reads
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "vlsu_defs.svh"

module vlsu_vrf_stage
  import vlsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  vlsu_req_if.stage  req,
  rob_if.drain       rob,
  output logic       st_valid_o,
  output elen_t      st_data_o,
  input  logic       st_take_i,
  output vreg_addr_t vrf_waddr_o,
  output elen_t      vrf_wdata_o,
  output logic       vrf_we_o,
  output strb_t      vrf_wbe_o,
  input  logic       vrf_wvalid_i,
  output vreg_addr_t vrf_raddr_o,
  output logic       vrf_re_o,
  input  elen_t      vrf_rdata_i,
  input  logic       vrf_rvalid_i,
  output logic       done_o
);

  vl_t        count;
  logic [2:0] step;
  logic       active;
  logic       advance;
  vreg_addr_t word_addr;
  offset_t    lane;
  offset_t    lane_back;
  offset_t    mem_off;
  strb_t      lane_be;

  vlsu_elem_counter u_counter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req      (req),
    .advance_i(advance),
    .count_o  (count),
    .step_o   (step),
    .active_o (active),
    .last_o   ()
  );

  assign word_addr = (vreg_addr_t'(req.vd) << $clog2(`VLSU_VELE)) +
                     vreg_addr_t'(count >> $clog2(`VLSU_ELENB));
  assign lane      = offset_t'(count);
  assign lane_back = -lane;

  // Byte lane the element occupied in the memory word
  assign mem_off = req.is_strided ?
                   offset_t'(req.base) + offset_t'((count >> req.vsew) * req.stride) :
                   offset_t'(req.base) + lane;

  always_comb begin
    lane_be = '0;
    if (req.single_elem) begin
      lane_be = elem_mask(req.vsew) << lane;
    end else begin
      for (int k = 0; k < $bits(strb_t); k++) begin
        lane_be[k] = (k < step);
      end
    end
  end

  //////////////////////////////////////////////////
  // Load write-back
  //////////////////////////////////////////////////

  assign vrf_waddr_o = word_addr;
  assign vrf_we_o    = req.is_load && active && rob.head_valid;
  assign vrf_wdata_o = rotl_bytes(rob.head_data, lane - mem_off);
  assign vrf_wbe_o   = lane_be;
  assign rob.pop     = vrf_we_o && vrf_wvalid_i;

  //////////////////////////////////////////////////
  // Store reads
  //////////////////////////////////////////////////

  // Read held until answered, only with room in the hold register
  assign vrf_raddr_o = word_addr;
  assign vrf_re_o    = !req.is_load && active && st_take_i;
  assign st_valid_o  = vrf_re_o && vrf_rvalid_i;
  // Strided element goes to lane 0
  assign st_data_o   = req.is_strided ? rotl_bytes(vrf_rdata_i, lane_back) : vrf_rdata_i;

  assign advance = rob.pop || st_valid_o;
  assign done_o  = !active;

endmodule

// File: src/vlsu_mem_stage.sv
//////////////////////////////////////////////////
// Memory stage
// Address generation, request issue, store alignment
//////////////////////////////////////////////////

`timescale 1ns/1ns

module vlsu_mem_stage
  import vlsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  vlsu_req_if.stage req,
  rob_if.fill       rob,
  input  logic      st_valid_i,
  input  elen_t     st_data_i,
  output logic      st_take_o,
  output logic      mem_valid_o,
  input  logic      mem_ready_i,
  output mem_addr_t mem_addr_o,
  output logic      mem_we_o,
  output strb_t     mem_strb_o,
  output elen_t     mem_wdata_o,
  output rob_id_t   mem_id_o,
  output logic      mem_last_o,
  input  logic      mem_result_valid_i,
  input  rob_id_t   mem_result_id_i,
  input  elen_t     mem_result_rdata_i,
  output logic      done_o
);

  vl_t        count;
  logic [2:0] step;
  logic       active;
  logic       fire;
  mem_addr_t  elem_addr;
  offset_t    offset;
  strb_t      lane_strb;
  logic       hold_valid_q;
  elen_t      hold_data_q;

  vlsu_elem_counter u_counter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req      (req),
    .advance_i(fire),
    .count_o  (count),
    .step_o   (step),
    .active_o (active),
    .last_o   (mem_last_o)
  );

  //////////////////////////////////////////////////
  // Address and strobe
  //////////////////////////////////////////////////

  always_comb begin
    if (req.is_strided) begin
      elem_addr = req.base + mem_addr_t'(count >> req.vsew) * req.stride;
    end else begin
      elem_addr = req.base + mem_addr_t'(count);
    end
  end

  assign offset     = elem_addr[$bits(offset_t)-1:0];
  assign mem_addr_o = {elem_addr[$bits(mem_addr_t)-1:$bits(offset_t)], offset_t'(0)};

  always_comb begin
    lane_strb = '0;
    if (req.single_elem) begin
      lane_strb = elem_mask(req.vsew) << offset;
    end else begin
      for (int k = 0; k < $bits(strb_t); k++) begin
        lane_strb[k] = (k < step);
      end
    end
  end

  // Loads wait for a free tag, stores for a held word
  assign mem_valid_o = active && (req.is_load ? !rob.full : hold_valid_q);
  assign fire        = mem_valid_o && mem_ready_i;
  assign mem_we_o    = !req.is_load;
  assign mem_strb_o  = lane_strb;
  assign mem_id_o    = rob.alloc_id;
  assign done_o      = !active;

  // Strided words arrive in lane 0, unit-stride words in VRF lanes
  assign mem_wdata_o = rotl_bytes(hold_data_q,
                                  req.is_strided ? offset : offset_t'(req.base));

  // Load tags and returning results
  assign rob.alloc     = fire && req.is_load;
  assign rob.push      = mem_result_valid_i;
  assign rob.push_id   = mem_result_id_i;
  assign rob.push_data = mem_result_rdata_i;

  //////////////////////////////////////////////////
  // Store hold register
  //////////////////////////////////////////////////

  assign st_take_o = !hold_valid_q || (fire && !req.is_load);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
    end else if (st_valid_i && st_take_o) begin
      hold_valid_q <= 1'b1;
    end else if (fire && !req.is_load) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_valid_i && st_take_o) begin
      hold_data_q <= st_data_i;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
    $stable(mem_strb_o) && $stable(mem_wdata_o) && $stable(mem_id_o));

endmodule

// File: src/reorder_buffer.sv
//////////////////////////////////////////////////
// Reorder buffer
// Tags loads, takes results in any order, drains in order
//////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_buffer
  import vlsu_pkg::*;
#(
  parameter int unsigned DEPTH = 8
) (
  input logic   clk_i,
  input logic   rst_i,
  rob_if.buffer rob
);

  elen_t                  data_q [DEPTH];
  logic [DEPTH-1:0]       valid_q;
  rob_id_t                alloc_ptr_q;
  rob_id_t                head_ptr_q;
  logic [$clog2(DEPTH):0] used_q;

  function automatic rob_id_t next_id(rob_id_t id);
    return (id == rob_id_t'(DEPTH - 1)) ? '0 : id + 1'b1;
  endfunction

  assign rob.alloc_id   = alloc_ptr_q;
  assign rob.full       = (used_q == DEPTH);
  assign rob.head_valid = valid_q[head_ptr_q];
  assign rob.head_data  = data_q[head_ptr_q];

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      alloc_ptr_q <= '0;
      head_ptr_q  <= '0;
      used_q      <= '0;
      valid_q     <= '0;
    end else begin
      if (rob.alloc) begin
        alloc_ptr_q <= next_id(alloc_ptr_q);
      end
      if (rob.pop) begin
        valid_q[head_ptr_q] <= 1'b0;
        head_ptr_q          <= next_id(head_ptr_q);
      end
      // A pushed ID is never the one popping this cycle
      if (rob.push) begin
        valid_q[rob.push_id] <= 1'b1;
      end
      if (rob.alloc && !rob.pop) begin
        used_q <= used_q + 1'b1;
      end else if (!rob.alloc && rob.pop) begin
        used_q <= used_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rob.push) begin
      data_q[rob.push_id] <= rob.push_data;
    end
  end

  a_no_alloc_full: assert property (@(posedge clk_i) disable iff (rst_i)
    rob.alloc |-> !rob.full);

  a_no_pop_unwritten: assert property (@(posedge clk_i) disable iff (rst_i)
    rob.pop |-> rob.head_valid);

endmodule

// File: src/vlsu_elem_counter.sv
//////////////////////////////////////////////////
// Byte progress counter
// Steps through a request in element or word beats
//////////////////////////////////////////////////

`timescale 1ns/1ns

module vlsu_elem_counter
  import vlsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  vlsu_req_if.stage  req,
  input  logic       advance_i,
  output vl_t        count_o,
  output logic [2:0] step_o,
  output logic       active_o,
  output logic       last_o
);

  vl_t        count_q;
  vl_t        remaining;
  logic [2:0] unit;

  assign remaining = req.total_bytes - count_q;
  // One element per beat when strided or unaligned
  assign unit      = req.single_elem ? req.elem_bytes : 3'd4;
  assign active_o  = req.busy && (remaining != '0);
  assign last_o    = active_o && (remaining <= vl_t'(unit));
  // Tail beat takes what is left
  assign step_o    = last_o ? remaining[2:0] : unit;
  assign count_o   = count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (req.start) begin
      count_q <= '0;
    end else if (advance_i && active_o) begin
      count_q <= count_q + vl_t'(step_o);
    end
  end

endmodule

// File: src/vlsu_ctrl.sv
//////////////////////////////////////////////////
// Vector LSU control
// Latches one request and tracks it to the end
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "vlsu_defs.svh"

module vlsu_ctrl
  import vlsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_valid_i,
  input  vlsu_op_e              req_op_i,
  input  vsew_e                 req_vsew_i,
  input  logic [`VLSU_VL_W-1:0] req_vl_i,
  input  mem_addr_t             req_base_i,
  input  mem_addr_t             req_stride_i,
  input  vreg_idx_t             req_vd_i,
  output logic                  req_ready_o,
  output logic                  finished_o,
  vlsu_req_if.ctrl              req,
  input  logic                  mem_done_i,
  input  logic                  vrf_done_i
);

  vlsu_op_e  op_q;
  vsew_e     vsew_q;
  vl_t       bytes_q;
  mem_addr_t base_q;
  mem_addr_t stride_q;
  vreg_idx_t vd_q;
  logic      busy_q;
  logic      accept;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;
  assign finished_o  = busy_q && mem_done_i && vrf_done_i;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= req_op_i;
      vsew_q   <= req_vsew_i;
      // Element count to byte count
      bytes_q  <= vl_t'(req_vl_i) << req_vsew_i;
      base_q   <= req_base_i;
      stride_q <= req_stride_i;
      vd_q     <= req_vd_i;
    end
  end

  // Zero-length requests are consumed without going busy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (accept && (req_vl_i != '0)) begin
      busy_q <= 1'b1;
    end else if (finished_o) begin
      busy_q <= 1'b0;
    end
  end

  // Decode
  assign req.start       = accept && (req_vl_i != '0);
  assign req.busy        = busy_q;
  assign req.is_load     = (op_q == LOAD_UNIT) || (op_q == LOAD_STRIDED);
  assign req.is_strided  = (op_q == LOAD_STRIDED) || (op_q == STORE_STRIDED);
  assign req.single_elem = req.is_strided || (base_q[1:0] != 2'b00);
  assign req.vsew        = vsew_q;
  assign req.elem_bytes  = 3'd1 << vsew_q;
  assign req.total_bytes = bytes_q;
  assign req.base        = base_q;
  assign req.stride      = stride_q;
  assign req.vd          = vd_q;

  // A started request keeps both stages active for at least one beat
  a_start_not_done: assert property (@(posedge clk_i) disable iff (rst_i)
    req.start |=> !mem_done_i && !vrf_done_i);

endmodule

// File: src/vlsu_ifs.sv
//////////////////////////////////////////////////
// Vector LSU interfaces
// Decoded request bundle and reorder buffer port
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface vlsu_req_if
  import vlsu_pkg::*;
();
  logic       start;
  logic       busy;
  logic       is_load;
  logic       is_strided;
  logic       single_elem;
  vsew_e      vsew;
  logic [2:0] elem_bytes;
  vl_t        total_bytes;
  mem_addr_t  base;
  mem_addr_t  stride;
  vreg_idx_t  vd;

  modport ctrl (output start, busy, is_load, is_strided, single_elem, vsew,
                elem_bytes, total_bytes, base, stride, vd);
  modport stage (input start, busy, is_load, is_strided, single_elem, vsew,
                 elem_bytes, total_bytes, base, stride, vd);
endinterface

interface rob_if
  import vlsu_pkg::*;
();
  logic    alloc;
  rob_id_t alloc_id;
  logic    full;
  logic    push;
  rob_id_t push_id;
  elen_t   push_data;
  logic    pop;
  logic    head_valid;
  elen_t   head_data;

  modport buffer (input alloc, push, push_id, push_data, pop,
                  output alloc_id, full, head_valid, head_data);
  modport fill (output alloc, push, push_id, push_data, input alloc_id, full);
  modport drain (output pop, input head_valid, head_data);
endinterface

// File: src/vlsu_pkg.sv
//////////////////////////////////////////////////
// Vector LSU package
// Opcodes, element widths, data types, lane helpers
//////////////////////////////////////////////////

`include "vlsu_defs.svh"

package vlsu_pkg;

  typedef enum logic [1:0] {
    LOAD_UNIT,
    LOAD_STRIDED,
    STORE_UNIT,
    STORE_STRIDED
  } vlsu_op_e;

  typedef enum logic [1:0] {
    EW_8,
    EW_16,
    EW_32
  } vsew_e;

  typedef logic [`VLSU_ELEN-1:0]                          elen_t;
  typedef logic [`VLSU_ELENB-1:0]                         strb_t;
  typedef logic [`VLSU_ADDR_W-1:0]                        mem_addr_t;
  typedef logic [$clog2(`VLSU_NR_VREGS*`VLSU_VELE)-1:0]   vreg_addr_t;
  typedef logic [$clog2(`VLSU_NR_VREGS)-1:0]              vreg_idx_t;
  // Byte count, four times the element count at most
  typedef logic [`VLSU_VL_W+1:0]                          vl_t;
  typedef logic [$clog2(`VLSU_OUTSTANDING)-1:0]           rob_id_t;
  typedef logic [$clog2(`VLSU_ELENB)-1:0]                 offset_t;

  // Rotate a word towards higher byte lanes
  function automatic elen_t rotl_bytes(elen_t data, offset_t sh);
    return (data << (8 * sh)) | (data >> (`VLSU_ELEN - 8 * sh));
  endfunction

  // Byte enables of one element in lane 0
  function automatic strb_t elem_mask(vsew_e ew);
    case (ew)
      EW_8:    return strb_t'(4'b0001);
      EW_16:   return strb_t'(4'b0011);
      default: return strb_t'(4'b1111);
    endcase
  endfunction

endpackage

// File: src/vlsu_defs.svh
//////////////////////////////////////////////////
// Vector LSU constants
// Data, address and register file geometry
//////////////////////////////////////////////////

`ifndef VLSU_DEFS_SVH
`define VLSU_DEFS_SVH

// Element word and its byte lanes
`define VLSU_ELEN 32
`define VLSU_ELENB 4

// VRF geometry
`define VLSU_VELE 8
`define VLSU_NR_VREGS 32

`define VLSU_VL_W 8
`define VLSU_ADDR_W 32

// Reorder buffer depth, power of two
`define VLSU_OUTSTANDING 8

`endif
